/* Makefile */
TOOL     = verilator
FLAGS    = --timing --assert --timescale 1ns/1ns
TOP      = memStageTb
FILELIST = sources.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q '^>>> PASS$$' $(LOG) && echo "simulation passed" || \
		(echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)

/* hw/byteMem.sv */
`timescale 1ns/1ns

module byteMem #(
   parameter int addrBits = 10
) (
   input  logic                clk,
   input  memPkg::byteEnT      we,
   input  logic [addrBits-1:0] wAddr,
   input  memPkg::wordT        writeData,
   input  logic [addrBits-1:0] rAddr,
   output memPkg::wordT        rData
);

   localparam int depth = 2 ** addrBits;

   memPkg::wordT mem [depth];

   // per-lane write, lane i holds bits i*8 +: 8
   always_ff @(posedge clk) begin
      for (int i = 0; i < memPkg::laneCount; i++) begin
         if (we[i]) begin
            mem[wAddr][i*memPkg::byteBits +: memPkg::byteBits] <=
               writeData[i*memPkg::byteBits +: memPkg::byteBits];
         end
      end
   end

   // registered read, returns old data on a same-edge write
   always_ff @(posedge clk) begin
      rData <= mem[rAddr];
   end

endmodule

/* hw/loadExtract.sv */
`timescale 1ns/1ns

module loadExtract (
   input  memPkg::opcodeT loadOp,
   input  memPkg::offsetT loadOffset,
   input  memPkg::wordT   rData,
   output memPkg::wordT   loadData
);

   logic [7:0]  selByte;
   logic [15:0] selHalf;

   // big-endian lanes, offset 0 is the top byte
   always_comb begin
      case (loadOffset)
         2'b00:   selByte = rData[31:24];
         2'b01:   selByte = rData[23:16];
         2'b10:   selByte = rData[15:8];
         default: selByte = rData[7:0];
      endcase
   end

   assign selHalf = loadOffset[1] ? rData[15:0] : rData[31:16];

   always_comb begin
      case (loadOp)
         memPkg::opLb:   loadData = {{24{selByte[7]}}, selByte};
         memPkg::opLbu:  loadData = {24'b0, selByte};
         memPkg::opLh:   loadData = {{16{selHalf[15]}}, selHalf};
         memPkg::opLhu:  loadData = {16'b0, selHalf};
         memPkg::opNone: loadData = '0;   // idle after reset
         default:        loadData = rData;   // lw and the rest
      endcase
   end

endmodule

/* hw/memPkg.sv */
package memPkg;

   localparam int opcodeBits = 6;
   localparam int wordBits   = 32;
   localparam int byteBits   = 8;
   localparam int laneCount  = wordBits / byteBits;
   localparam int offsetBits = $clog2(laneCount);

   typedef logic [opcodeBits-1:0] opcodeT;
   typedef logic [wordBits-1:0]   wordT;
   typedef logic [laneCount-1:0]  byteEnT;   // bit 3 is the byte at offset 0
   typedef logic [offsetBits-1:0] offsetT;

   // idle value of the registered load opcode
   localparam opcodeT opNone = 6'h00;

   // MIPS load opcodes
   localparam opcodeT opLb  = 6'h20;
   localparam opcodeT opLh  = 6'h21;
   localparam opcodeT opLw  = 6'h23;
   localparam opcodeT opLbu = 6'h24;
   localparam opcodeT opLhu = 6'h25;

   // MIPS store opcodes
   localparam opcodeT opSb  = 6'h28;
   localparam opcodeT opSh  = 6'h29;
   localparam opcodeT opSw  = 6'h2B;

endpackage

/* hw/memStage.sv */
`timescale 1ns/1ns

module memStage #(
   parameter int dataAddrBits  = 10,
   parameter int instrAddrBits = 10
) (
   input  logic           clk,
   input  logic           rstN,
   input  memPkg::opcodeT opcode,
   input  memPkg::wordT   aluOut,
   input  memPkg::wordT   storeData,
   input  logic           stall,
   input  memPkg::wordT   pc,
   output memPkg::wordT   loadData,
   output memPkg::wordT   instr
);

   memPkg::byteEnT dataWe;
   memPkg::byteEnT instrWe;
   memPkg::opcodeT loadOp;
   memPkg::offsetT loadOffset;
   memPkg::wordT   writeData;
   memPkg::wordT   dataRData;

   writeEnCtrl weCtrl (
      .clk        (clk),
      .rstN       (rstN),
      .opcode     (opcode),
      .addrNibble (aluOut[31:28]),
      .offset     (aluOut[1:0]),
      .stall      (stall),
      .dataWe     (dataWe),
      .instrWe    (instrWe),
      .loadOp     (loadOp),
      .loadOffset (loadOffset)
   );

   storeAlign align (
      .opcode    (opcode),
      .storeData (storeData),
      .writeData (writeData)
   );

   // loads and stores share the low word address
   byteMem #(.addrBits(dataAddrBits)) dataMem (
      .clk       (clk),
      .we        (dataWe),
      .wAddr     (aluOut[dataAddrBits+1:2]),
      .writeData (writeData),
      .rAddr     (aluOut[dataAddrBits+1:2]),
      .rData     (dataRData)
   );

   // fetch port reads by pc
   byteMem #(.addrBits(instrAddrBits)) instrMem (
      .clk       (clk),
      .we        (instrWe),
      .wAddr     (aluOut[instrAddrBits+1:2]),
      .writeData (writeData),
      .rAddr     (pc[instrAddrBits+1:2]),
      .rData     (instr)
   );

   loadExtract extract (
      .loadOp     (loadOp),
      .loadOffset (loadOffset),
      .rData      (dataRData),
      .loadData   (loadData)
   );

endmodule

/* hw/storeAlign.sv */
`timescale 1ns/1ns

module storeAlign (
   input  memPkg::opcodeT opcode,
   input  memPkg::wordT   storeData,
   output memPkg::wordT   writeData
);

   logic [7:0]  storeByte;
   logic [15:0] storeHalf;

   assign storeByte = storeData[7:0];
   assign storeHalf = storeData[15:0];

   // copy the value onto every lane it may go to
   // the byte enables pick the lane that is actually written
   always_comb begin
      case (opcode)
         memPkg::opSb: writeData = {4{storeByte}};
         memPkg::opSh: writeData = {2{storeHalf}};
         default:      writeData = storeData;   // sw, or no store at all
      endcase
   end

endmodule

/* hw/writeEnCtrl.sv */
`timescale 1ns/1ns

module writeEnCtrl (
   input  logic           clk,
   input  logic           rstN,
   input  memPkg::opcodeT opcode,
   input  logic [3:0]     addrNibble,   // aluOut[31:28]
   input  memPkg::offsetT offset,
   input  logic           stall,
   output memPkg::byteEnT dataWe,
   output memPkg::byteEnT instrWe,
   output memPkg::opcodeT loadOp,
   output memPkg::offsetT loadOffset
);

   logic           isDataSpace;
   logic           isInstrSpace;
   memPkg::byteEnT laneEn;

   // byte enables for a store, independent of the target space
   function automatic memPkg::byteEnT storeLanes(input memPkg::opcodeT op,
                                                 input memPkg::offsetT off);
      memPkg::byteEnT lanes;
      lanes = '0;
      case (op)
         memPkg::opSb: begin
            case (off)
               2'b00: lanes = 4'b1000;   // big-endian, offset 0 is msb
               2'b01: lanes = 4'b0100;
               2'b10: lanes = 4'b0010;
               2'b11: lanes = 4'b0001;
               default: lanes = '0;
            endcase
         end
         memPkg::opSh: begin
            if (off[1]) begin
               lanes = 4'b0011;
            end else begin
               lanes = 4'b1100;
            end
         end
         memPkg::opSw: lanes = 4'b1111;
         default:      lanes = '0;    // not a store
      endcase
      return lanes;
   endfunction

   // 0x3 falls in both spaces, so both memories take that store
   assign isDataSpace  = !addrNibble[3] && !addrNibble[2] && addrNibble[0];
   assign isInstrSpace = !addrNibble[3] && addrNibble[1];

   assign laneEn = storeLanes(opcode, offset);

   always_comb begin
      dataWe  = '0;
      instrWe = '0;
      if (!stall) begin   // a stalled store must not land
         if (isDataSpace) begin
            dataWe = laneEn;
         end
         if (isInstrSpace) begin
            instrWe = laneEn;
         end
      end
   end

   // load controls follow the data memory read by one cycle
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         loadOp     <= memPkg::opNone;
         loadOffset <= '0;
      end else begin
         loadOp     <= opcode;
         loadOffset <= offset;
      end
   end

endmodule

/* sources.f */
hw/memPkg.sv
hw/writeEnCtrl.sv
hw/storeAlign.sv
hw/byteMem.sv
hw/loadExtract.sv
hw/memStage.sv
verif/clockGen.sv
verif/memStage_assertions.sv
verif/memStageTb.sv

/* verif/clockGen.sv */
`timescale 1ns/1ns

module clockGen #(
   parameter int periodNs = 20
) (
   output logic clk
);

   initial begin
      clk = 1'b0;
      forever #(periodNs / 2) clk = ~clk;   // free running, starts low
   end

endmodule

/* verif/memStageTb.sv */
`timescale 1ns/1ns

module memStageTb;

   localparam string tracePath = "verif/memStage_trace.txt";

   logic           clk;
   logic           rstN;
   memPkg::opcodeT opcode;
   memPkg::wordT   aluOut;
   memPkg::wordT   storeData;
   logic           stall;
   memPkg::wordT   pc;
   memPkg::wordT   loadData;
   memPkg::wordT   instr;

   // one entry per trace step
   string          names[$];
   string          ops[$];
   memPkg::opcodeT opcodes[$];
   memPkg::wordT   addrs[$];
   memPkg::wordT   datas[$];
   logic           stalls[$];
   memPkg::wordT   expects[$];

   int   passCount  = 0;
   int   errorCount = 0;
   int   cycleCount = 0;
   int   cycleLimit = 20;
   logic traceOk;

   clockGen #(.periodNs(20)) clkGen (.clk(clk));

   memStage #(.dataAddrBits(10), .instrAddrBits(10)) dut (
      .clk       (clk),
      .rstN      (rstN),
      .opcode    (opcode),
      .aluOut    (aluOut),
      .storeData (storeData),
      .stall     (stall),
      .pc        (pc),
      .loadData  (loadData),
      .instr     (instr)
   );

   task automatic readTrace(output logic ok);
      int             fd;
      int             lineNo;
      int             fields;
      int             stallVal;
      string          line;
      string          name;
      string          op;
      memPkg::opcodeT opc;
      memPkg::wordT   addr;
      memPkg::wordT   data;
      memPkg::wordT   expected;
      lineNo = 0;
      fd = $fopen(tracePath, "r");
      ok = (fd != 0);
      if (fd != 0) begin
         while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            lineNo++;
            if (line.len() == 0 || line.getc(0) == "#" || line.getc(0) == "\n") begin
               continue;   // comment or blank
            end
            fields = $sscanf(line, "%s %s %h %h %h %d %h",
                             name, op, opc, addr, data, stallVal, expected);
            if (fields != 7 || !(op == "store" || op == "load" || op == "fetch")) begin
               errorCount++;
               $display("trace line %0d is malformed and was skipped", lineNo);
            end else begin
               names.push_back(name);
               ops.push_back(op);
               opcodes.push_back(opc);
               addrs.push_back(addr);
               datas.push_back(data);
               stalls.push_back(stallVal != 0);
               expects.push_back(expected);
            end
         end
         $fclose(fd);
      end
   endtask

   // called on a falling edge
   task automatic driveStep(input int i);
      opcode    = memPkg::opNone;
      aluOut    = '0;
      storeData = '0;
      stall     = stalls[i];
      if (ops[i] == "fetch") begin
         pc = addrs[i];   // fetch only moves pc
      end else begin
         opcode    = opcodes[i];
         aluOut    = addrs[i];
         storeData = datas[i];
      end
   endtask

   task automatic checkLoad(input string name, input memPkg::wordT expected,
                            input memPkg::wordT actual);
      if (actual !== expected) begin
         errorCount++;
         $display("[ERROR] %0t ns %s: loadData expected %h, got %h",
                  $time, name, expected, actual);
      end else begin
         passCount++;
         $display("ok    %s: loadData %h", name, actual);
      end
   endtask

   task automatic checkInstr(input string name, input memPkg::wordT expected,
                             input memPkg::wordT actual);
      if (actual !== expected) begin
         errorCount++;
         $display("[ERROR] %0t ns %s: instr expected %h, got %h",
                  $time, name, expected, actual);
      end else begin
         passCount++;
         $display("ok    %s: instr %h", name, actual);
      end
   endtask

   initial begin
      rstN      = 1'b0;
      opcode    = memPkg::opNone;
      aluOut    = '0;
      storeData = '0;
      stall     = 1'b0;
      pc        = '0;
      readTrace(traceOk);
      cycleLimit = 4 * names.size() + 20;
      if (!traceOk) begin
         $display("could not open %s, no tests were run", tracePath);
         $display(">>> FAIL");
         $finish;
      end else begin
         repeat (4) @(posedge clk);   // four clock cycles in reset
         @(negedge clk);
         rstN = 1'b1;   // released on a falling edge
         for (int i = 0; i < names.size(); i++) begin
            driveStep(i);
            @(negedge clk);   // registered outputs settled
            if (ops[i] == "load") begin
               checkLoad(names[i], expects[i], loadData);
            end else if (ops[i] == "fetch") begin
               checkInstr(names[i], expects[i], instr);
            end
         end
         $display("tests passed %0d, errors %0d", passCount, errorCount);
         if (errorCount == 0) begin
            $display(">>> PASS");
         end else begin
            $display(">>> FAIL");
         end
         $finish;
      end
   end

   always @(posedge clk) begin
      cycleCount++;
      if (cycleCount >= cycleLimit) begin
         $display("timeout, the run did not finish within %0d cycles", cycleLimit);
         $display(">>> FAIL");
         $finish;
      end
   end

endmodule

/* verif/memStage_assertions.sv */
`timescale 1ns/1ns

module memStageAssertions (
   input logic           clk,
   input logic           rstN,
   input memPkg::opcodeT opcode,
   input logic           stall,
   input memPkg::byteEnT dataWe,
   input memPkg::byteEnT instrWe
);

   logic isStore;

   assign isStore = (opcode == memPkg::opSb) || (opcode == memPkg::opSh) ||
                    (opcode == memPkg::opSw);

   // single bytes, aligned halves or the full word
   function automatic logic legalLanes(input memPkg::byteEnT lanes);
      return lanes inside {4'b1000, 4'b0100, 4'b0010, 4'b0001, 4'b1100, 4'b0011, 4'b1111};
   endfunction

   stallNoWrite: assert property (@(posedge clk) disable iff (!rstN)
      stall |-> (dataWe == '0 && instrWe == '0))
      else $error("byte enable active while the pipeline is stalled");

   loadNoWrite: assert property (@(posedge clk) disable iff (!rstN)
      !isStore |-> (dataWe == '0 && instrWe == '0))
      else $error("byte enable active without a store opcode");

   dataLanesLegal: assert property (@(posedge clk) disable iff (!rstN)
      (dataWe != '0) |-> legalLanes(dataWe))
      else $error("illegal data memory byte enable pattern %b", dataWe);

   instrLanesLegal: assert property (@(posedge clk) disable iff (!rstN)
      (instrWe != '0) |-> legalLanes(instrWe))
      else $error("illegal instruction memory byte enable pattern %b", instrWe);

endmodule

bind writeEnCtrl memStageAssertions asrt (
   .clk     (clk),
   .rstN    (rstN),
   .opcode  (opcode),
   .stall   (stall),
   .dataWe  (dataWe),
   .instrWe (instrWe)
);

/* verif/memStage_trace.txt */
# columns: name op(store|load|fetch) opcode address storeData stall expected
# all hex except stall; expected is checked on load and fetch lines only
reset_idle    load  00 10000010 00000000 0 00000000
sw_word       store 2B 10000010 11223344 0 00000000
lw_sw_word    load  23 10000010 00000000 0 11223344
sh_off0       store 29 10000010 9999AABB 0 00000000
lw_sh_off0    load  23 10000010 00000000 0 AABB3344
sh_off2       store 29 10000012 0000CCDD 0 00000000
lw_sh_off2    load  23 10000010 00000000 0 AABBCCDD
sb_off0       store 28 10000010 12345611 0 00000000
lw_sb_off0    load  23 10000010 00000000 0 11BBCCDD
sb_off1       store 28 10000011 00000022 0 00000000
lw_sb_off1    load  23 10000010 00000000 0 1122CCDD
sb_off2       store 28 10000012 FFFFFF33 0 00000000
lw_sb_off2    load  23 10000010 00000000 0 112233DD
sb_off3       store 28 10000013 00000044 0 00000000
lw_sb_off3    load  23 10000010 00000000 0 11223344
sw_sign       store 2B 10000020 807F7FF0 0 00000000
lb_off0       load  20 10000020 00000000 0 FFFFFF80
lb_off1       load  20 10000021 00000000 0 0000007F
lb_off2       load  20 10000022 00000000 0 0000007F
lb_off3       load  20 10000023 00000000 0 FFFFFFF0
lbu_off0      load  24 10000020 00000000 0 00000080
lbu_off1      load  24 10000021 00000000 0 0000007F
lbu_off2      load  24 10000022 00000000 0 0000007F
lbu_off3      load  24 10000023 00000000 0 000000F0
lh_off0       load  21 10000020 00000000 0 FFFF807F
lh_off2       load  21 10000022 00000000 0 00007FF0
lhu_off0      load  25 10000020 00000000 0 0000807F
lhu_off2      load  25 10000022 00000000 0 00007FF0
sw_stalled    store 2B 10000010 DEADBEEF 1 00000000
lw_stalled    load  23 10000010 00000000 1 11223344
sw_data_init  store 2B 10000030 0A0A0A0A 0 00000000
sw_instr_0x2  store 2B 20000030 0B0B0B0B 0 00000000
fetch_0x2     fetch 00 00000030 00000000 0 0B0B0B0B
lw_after_0x2  load  23 10000030 00000000 0 0A0A0A0A
sw_both_0x3   store 2B 30000030 0C0C0C0C 0 00000000
fetch_0x3     fetch 00 00000030 00000000 0 0C0C0C0C
lw_after_0x3  load  23 10000030 00000000 0 0C0C0C0C
sw_none_0x0   store 2B 00000030 0D0D0D0D 0 00000000
fetch_0x0     fetch 00 00000030 00000000 0 0C0C0C0C
lw_after_0x0  load  23 10000030 00000000 0 0C0C0C0C
